// ==== hw/ringbuf_pkg.sv ====
/*
 * ring buffer shared definitions
 * widths, depth, register map, egress states and APB structs
 */
package ringbuf_pkg;

   localparam int DATA_W = 32;
   localparam int DEPTH  = 64;
   localparam int ADDR_W = 6;
   // one extra bit so that a full ring can be counted
   localparam int CNT_W  = 7;
   localparam int APB_AW = 4;

   typedef enum logic [APB_AW-1:0] {
      REG_DATA   = 4'h0,
      REG_STATUS = 4'h4
   } apb_reg_e;

   // skid store occupancy in the egress block
   typedef enum logic [1:0] {
      EG_EMPTY = 2'd0,
      EG_ONE   = 2'd1,
      EG_TWO   = 2'd2
   } egress_state_e;

   // driven by the APB requester
   typedef struct packed {
      logic              psel;
      logic              penable;
      logic              pwrite;
      logic [APB_AW-1:0] paddr;
      logic [DATA_W-1:0] pwdata;
   } apb_req_t;

   // driven by the APB slave
   typedef struct packed {
      logic [DATA_W-1:0] prdata;
      logic              pready;
      logic              pslverr;
   } apb_rsp_t;

endpackage

// ==== hw/mem_1rw_sync.sv ====
/*
 * synchronous single-port RAM
 * one read or one write per cycle, read data registered
 */
`timescale 1ns/1ps

module mem_1rw_sync #(
   parameter int width = 32,
   parameter int els   = 64
) (
   input  logic                     clk_i,
   input  logic                     v_i,
   input  logic                     w_i,
   input  logic [$clog2(els)-1:0]   addr_i,
   input  logic [width-1:0]         data_i,
   output logic [width-1:0]         data_o
);

   logic [width-1:0] mem_q [els];

   // data_o keeps the last read word until the next read
   always_ff @(posedge clk_i)
   begin
      if (v_i)
      begin
         if (w_i)
            mem_q[addr_i] <= data_i;
         else
            data_o <= mem_q[addr_i];
      end
   end

endmodule

// ==== hw/apb_ingress.sv ====
/*
 * APB slave front end
 * data writes become push requests, status reads return the fill count
 */
`timescale 1ns/1ps

module apb_ingress (
   input  logic                           clk_i,
   input  logic                           rst_n_i,
   input  ringbuf_pkg::apb_req_t          apb_req_i,
   output ringbuf_pkg::apb_rsp_t          apb_rsp_o,
   output logic                           push_valid_o,
   output logic [ringbuf_pkg::DATA_W-1:0] push_data_o,
   input  logic                           push_grant_i,
   input  logic [ringbuf_pkg::CNT_W-1:0]  fill_count_i
);

   logic                          access;
   logic                          setup;
   logic                          data_wr;
   logic                          status_rd;
   logic                          bad_access;
   logic [ringbuf_pkg::CNT_W-1:0] status_q;

   assign access = apb_req_i.psel & apb_req_i.penable;
   assign setup  = apb_req_i.psel & ~apb_req_i.penable;

   assign data_wr   = access & apb_req_i.pwrite & (apb_req_i.paddr == ringbuf_pkg::REG_DATA);
   assign status_rd = access & ~apb_req_i.pwrite & (apb_req_i.paddr == ringbuf_pkg::REG_STATUS);
   // wrong direction or unused offset
   assign bad_access = access & ~data_wr & ~status_rd;

   // fill count sampled at the end of setup so it is ready in the access cycle
   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
         status_q <= '0;
      else if (setup)
         status_q <= fill_count_i;
   end

   assign push_valid_o = data_wr;
   assign push_data_o  = apb_req_i.pwdata;

   // a data write waits for the ring, everything else completes at once
   assign apb_rsp_o.pready  = data_wr ? push_grant_i : (status_rd | bad_access);
   assign apb_rsp_o.pslverr = bad_access;
   assign apb_rsp_o.prdata  = status_rd ?
      {{(ringbuf_pkg::DATA_W - ringbuf_pkg::CNT_W){1'b0}}, status_q} : '0;

endmodule

// ==== hw/ring_store.sv ====
/*
 * ring storage around a single-port RAM
 * keeps head, tail and fill count and arbitrates push against read
 */
`timescale 1ns/1ps

module ring_store (
   input  logic                           clk_i,
   input  logic                           rst_n_i,
   input  logic                           push_valid_i,
   input  logic [ringbuf_pkg::DATA_W-1:0] push_data_i,
   output logic                           push_grant_o,
   input  logic                           rd_req_i,
   output logic                           rd_grant_o,
   output logic [ringbuf_pkg::DATA_W-1:0] rd_data_o,
   output logic [ringbuf_pkg::CNT_W-1:0]  fill_count_o
);

   logic [ringbuf_pkg::ADDR_W-1:0] head_q;
   logic [ringbuf_pkg::ADDR_W-1:0] tail_q;
   logic [ringbuf_pkg::CNT_W-1:0]  count_q;
   logic                           wr_prio_q;
   logic                           full;
   logic                           empty;
   logic                           wr_ok;
   logic                           rd_ok;
   logic                           mem_v;
   logic [ringbuf_pkg::ADDR_W-1:0] mem_addr;

   assign full  = (count_q == ringbuf_pkg::CNT_W'(ringbuf_pkg::DEPTH));
   assign empty = (count_q == '0);

   assign wr_ok = push_valid_i & ~full;
   assign rd_ok = rd_req_i & ~empty;

   // on a conflict the flag decides, otherwise the lone requester wins
   assign push_grant_o = wr_ok & (~rd_ok | wr_prio_q);
   assign rd_grant_o   = rd_ok & (~wr_ok | ~wr_prio_q);

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         head_q    <= '0;
         tail_q    <= '0;
         count_q   <= '0;
         wr_prio_q <= 1'b1;
      end
      else
      begin
         if (wr_ok & rd_ok)
            wr_prio_q <= ~wr_prio_q;

         if (push_grant_o)
         begin
            if (tail_q == ringbuf_pkg::ADDR_W'(ringbuf_pkg::DEPTH - 1))
               tail_q <= '0;
            else
               tail_q <= tail_q + 1'b1;
         end

         if (rd_grant_o)
         begin
            if (head_q == ringbuf_pkg::ADDR_W'(ringbuf_pkg::DEPTH - 1))
               head_q <= '0;
            else
               head_q <= head_q + 1'b1;
         end

         // only one grant per cycle, so the count moves by one at most
         if (push_grant_o)
            count_q <= count_q + 1'b1;
         else if (rd_grant_o)
            count_q <= count_q - 1'b1;
      end
   end

   assign mem_v    = push_grant_o | rd_grant_o;
   assign mem_addr = push_grant_o ? tail_q : head_q;

   mem_1rw_sync #(
      .width (ringbuf_pkg::DATA_W),
      .els   (ringbuf_pkg::DEPTH)
   ) u_mem (
      .clk_i  (clk_i),
      .v_i    (mem_v),
      .w_i    (push_grant_o),
      .addr_i (mem_addr),
      .data_i (push_data_i),
      .data_o (rd_data_o)
   );

   assign fill_count_o = count_q;

endmodule

// ==== hw/stream_egress.sv ====
/*
 * output stream consumer
 * requests ring reads, absorbs the RAM latency in a two-entry skid store
 */
`timescale 1ns/1ps

module stream_egress (
   input  logic                           clk_i,
   input  logic                           rst_n_i,
   output logic                           rd_req_o,
   input  logic                           rd_grant_i,
   input  logic [ringbuf_pkg::DATA_W-1:0] rd_data_i,
   output logic                           out_valid_o,
   output logic [ringbuf_pkg::DATA_W-1:0] out_data_o,
   input  logic                           out_ready_i
);

   ringbuf_pkg::egress_state_e             state_q;
   ringbuf_pkg::egress_state_e             state_d;
   logic                                   inflight_q;
   logic [1:0][ringbuf_pkg::DATA_W-1:0]    skid_q;
   logic                                   pop;
   logic [1:0]                             used;

   // stored words plus the word still coming back from the RAM
   assign used     = 2'(state_q) + 2'(inflight_q);
   assign rd_req_o = (used < 2'd2);

   assign out_valid_o = (state_q != ringbuf_pkg::EG_EMPTY);
   assign out_data_o  = skid_q[0];
   assign pop         = out_valid_o & out_ready_i;

   always_comb
   begin
      state_d = state_q;
      unique case (state_q)
         ringbuf_pkg::EG_EMPTY:
            if (inflight_q)
               state_d = ringbuf_pkg::EG_ONE;
         ringbuf_pkg::EG_ONE:
            if (inflight_q & ~pop)
               state_d = ringbuf_pkg::EG_TWO;
            else if (~inflight_q & pop)
               state_d = ringbuf_pkg::EG_EMPTY;
         ringbuf_pkg::EG_TWO:
            // credits keep a third word from arriving while both slots are full
            if (pop & ~inflight_q)
               state_d = ringbuf_pkg::EG_ONE;
         default:
            state_d = ringbuf_pkg::EG_EMPTY;
      endcase
   end

   always_ff @(posedge clk_i or negedge rst_n_i)
   begin
      if (!rst_n_i)
      begin
         state_q    <= ringbuf_pkg::EG_EMPTY;
         inflight_q <= 1'b0;
      end
      else
      begin
         state_q    <= state_d;
         inflight_q <= rd_grant_i;
      end
   end

   // slot 0 is the oldest word, slot 1 the next one
   always_ff @(posedge clk_i)
   begin
      if (pop)
      begin
         skid_q[0] <= (state_q == ringbuf_pkg::EG_TWO) ? skid_q[1] : rd_data_i;
         if (inflight_q)
            skid_q[1] <= rd_data_i;
      end
      else if (inflight_q)
      begin
         if (state_q == ringbuf_pkg::EG_EMPTY)
            skid_q[0] <= rd_data_i;
         else
            skid_q[1] <= rd_data_i;
      end
   end

endmodule

// ==== hw/ringbuf_top.sv ====
/*
 * APB ring buffer top level
 * ingress, ring store and stream egress wired together
 */
`timescale 1ns/1ps

module ringbuf_top (
   input  logic                           clk_i,
   input  logic                           rst_n_i,
   input  ringbuf_pkg::apb_req_t          apb_req_i,
   output ringbuf_pkg::apb_rsp_t          apb_rsp_o,
   output logic                           out_valid_o,
   output logic [ringbuf_pkg::DATA_W-1:0] out_data_o,
   input  logic                           out_ready_i
);

   logic                          push_valid;
   logic [ringbuf_pkg::DATA_W-1:0] push_data;
   logic                          push_grant;
   logic                          rd_req;
   logic                          rd_grant;
   logic [ringbuf_pkg::DATA_W-1:0] rd_data;
   logic [ringbuf_pkg::CNT_W-1:0]  fill_count;

   // producer
   apb_ingress u_ingress (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .apb_req_i    (apb_req_i),
      .apb_rsp_o    (apb_rsp_o),
      .push_valid_o (push_valid),
      .push_data_o  (push_data),
      .push_grant_i (push_grant),
      .fill_count_i (fill_count)
   );

   ring_store u_store (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .push_valid_i (push_valid),
      .push_data_i  (push_data),
      .push_grant_o (push_grant),
      .rd_req_i     (rd_req),
      .rd_grant_o   (rd_grant),
      .rd_data_o    (rd_data),
      .fill_count_o (fill_count)
   );

   // consumer
   stream_egress u_egress (
      .clk_i       (clk_i),
      .rst_n_i     (rst_n_i),
      .rd_req_o    (rd_req),
      .rd_grant_i  (rd_grant),
      .rd_data_i   (rd_data),
      .out_valid_o (out_valid_o),
      .out_data_o  (out_data_o),
      .out_ready_i (out_ready_i)
   );

endmodule

// ==== verification/tb_clock_gen.sv ====
/*
 * testbench clock and reset generator
 * 20 ns clock, reset held low for 16 cycles
 */
`timescale 1ns/1ps

module tb_clock_gen (
   output logic clk_o,
   output logic rst_n_o
);

   localparam int HALF_PERIOD = 10;
   localparam int RST_CYCLES  = 16;

   initial
   begin
      clk_o = 1'b0;
      forever #(HALF_PERIOD) clk_o = ~clk_o;
   end

   initial
   begin
      rst_n_o = 1'b0;
      repeat (RST_CYCLES) @(posedge clk_o);
      rst_n_o <= 1'b1;
   end

endmodule

// ==== verification/tb_ringbuf.sv ====
/*
 * ring buffer testbench
 * APB stimulus, queue model of accepted words and an output stream checker
 */
`timescale 1ns/1ps

module tb_ringbuf;

   logic                           clk;
   logic                           rst_n;
   ringbuf_pkg::apb_req_t          apb_req;
   ringbuf_pkg::apb_rsp_t          apb_rsp;
   logic                           out_valid;
   logic [ringbuf_pkg::DATA_W-1:0] out_data;
   logic                           out_ready;
   logic                           rand_ready;
   logic [31:0]                    exp_q[$];
   logic [31:0]                    exp_word;
   int                             accepted;
   int                             drained;
   int                             mismatch_errs;
   int                             other_errs;

   tb_clock_gen u_clk (
      .clk_o   (clk),
      .rst_n_o (rst_n)
   );

   ringbuf_top u_dut (
      .clk_i       (clk),
      .rst_n_i     (rst_n),
      .apb_req_i   (apb_req),
      .apb_rsp_o   (apb_rsp),
      .out_valid_o (out_valid),
      .out_data_o  (out_data),
      .out_ready_i (out_ready)
   );

   // status = words in the ring, i.e. pending words minus what egress holds
   function automatic int expected_status(input int n_accepted, input int n_drained);
      int pending;
      int in_egress;
      pending   = n_accepted - n_drained;
      in_egress = (pending < 2) ? pending : 2;
      return pending - in_egress;
   endfunction

   task automatic check_hex(input string name, input logic [31:0] got, input logic [31:0] exp);
      if (got !== exp)
      begin
         $display("Mismatch %s: got %08h expected %08h", name, got, exp);
         mismatch_errs++;
      end
   endtask

   // one APB transfer, sampled on the falling edge, completes on the next rising edge
   task automatic apb_access(input logic wr, input logic [ringbuf_pkg::APB_AW-1:0] addr,
                             input logic [31:0] wdata, input int max_wait,
                             output logic [31:0] rdata, output logic slverr,
                             output int waits, output bit done);
      ringbuf_pkg::apb_req_t req;
      req = '0;
      rdata = '0;
      slverr = 1'b0;
      waits = 0;
      done = 1'b0;
      @(posedge clk);
      req.psel   = 1'b1;
      req.pwrite = wr;
      req.paddr  = addr;
      req.pwdata = wdata;
      apb_req <= req;
      @(posedge clk);
      req.penable = 1'b1;
      apb_req <= req;
      while (!done && waits < max_wait)
      begin
         @(negedge clk);
         if (apb_rsp.pready)
         begin
            done   = 1'b1;
            rdata  = apb_rsp.prdata;
            slverr = apb_rsp.pslverr;
         end
         else
            waits++;
      end
      if (!done)
      begin
         $display("timeout: no pready for APB access to offset %h after %0d cycles", addr, waits);
         other_errs++;
      end
      @(posedge clk);
      apb_req <= '0;
   endtask

   task automatic write_word(input logic [31:0] word, input int max_wait, output int waits);
      logic [31:0] rdata;
      logic        slverr;
      bit          done;
      apb_access(1'b1, ringbuf_pkg::REG_DATA, word, max_wait, rdata, slverr, waits, done);
      if (done)
      begin
         check_hex("pslverr", 32'(slverr), 32'h0);
         exp_q.push_back(word);
         accepted++;
      end
   endtask

   task automatic read_status(input int expected);
      logic [31:0] rdata;
      logic        slverr;
      int          waits;
      bit          done;
      apb_access(1'b0, ringbuf_pkg::REG_STATUS, '0, 50, rdata, slverr, waits, done);
      check_hex("prdata", rdata, 32'(expected));
      check_hex("pslverr", 32'(slverr), 32'h0);
   endtask

   task automatic bad_access(input logic wr, input logic [ringbuf_pkg::APB_AW-1:0] addr);
      logic [31:0] rdata;
      logic        slverr;
      int          waits;
      bit          done;
      apb_access(wr, addr, 32'hdead_0000 | 32'(addr), 50, rdata, slverr, waits, done);
      check_hex("pslverr", 32'(slverr), 32'h1);
   endtask

   task automatic wait_drain(input int max_cycles);
      int n;
      n = 0;
      while (exp_q.size() != 0 && n < max_cycles)
      begin
         @(negedge clk);
         n++;
      end
      if (exp_q.size() != 0)
      begin
         $display("timeout: %0d words never left the output stream", exp_q.size());
         other_errs++;
      end
   endtask

   // a word transfers at the next rising edge when both are high here
   always @(negedge clk)
   begin
      if (rst_n && out_valid && out_ready)
      begin
         if (exp_q.size() == 0)
         begin
            $display("unexpected output word %08h with nothing pending, egress state %s",
                     out_data, u_dut.u_egress.state_q.name());
            other_errs++;
         end
         else
         begin
            exp_word = exp_q.pop_front();
            check_hex("out_data_o", out_data, exp_word);
            drained++;
         end
      end
   end

   always @(posedge clk)
   begin
      if (rand_ready)
         out_ready <= ($urandom() & 32'd1) != 32'd0;
   end

   initial
   begin
      int          waits;
      int          n;
      apb_req = '0;
      out_ready = 1'b0;
      rand_ready = 1'b0;
      accepted = 0;
      drained = 0;
      mismatch_errs = 0;
      other_errs = 0;
      void'($urandom(32'hcfd9_a9ca));
      n = 0;
      while (!rst_n && n < 100)
      begin
         @(posedge clk);
         n++;
      end
      if (!rst_n)
      begin
         $display("timeout: reset was never released");
         other_errs++;
      end

      // reset state
      @(negedge clk);
      check_hex("out_valid_o", 32'(out_valid), 32'h0);
      read_status(0);

      // order and integrity with the sink always ready
      @(posedge clk);
      out_ready <= 1'b1;
      for (int i = 0; i < 40; i++)
         write_word($urandom(), 100, waits);
      wait_drain(500);

      // fill ring and skid store, then one write must stall
      @(posedge clk);
      out_ready <= 1'b0;
      for (int i = 0; i < ringbuf_pkg::DEPTH + 2; i++)
         write_word($urandom(), 100, waits);
      read_status(expected_status(accepted, drained));
      fork
         write_word($urandom(), 400, waits);
         begin
            repeat (30) @(posedge clk);
            out_ready <= 1'b1;
         end
      join
      if (waits < 20)
      begin
         $display("write into a full buffer completed after only %0d wait cycles", waits);
         other_errs++;
      end
      wait_drain(1000);

      // quiescent status with words held back
      @(posedge clk);
      out_ready <= 1'b0;
      for (int i = 0; i < 10; i++)
         write_word($urandom(), 100, waits);
      repeat (10) @(posedge clk);
      read_status(expected_status(accepted, drained));

      // error decode leaves count and stream alone
      n = accepted;
      bad_access(1'b1, ringbuf_pkg::REG_STATUS);
      bad_access(1'b0, ringbuf_pkg::REG_DATA);
      bad_access(1'b1, 4'h8);
      bad_access(1'b0, 4'hc);
      read_status(expected_status(accepted, drained));
      check_hex("out_valid_o", 32'(out_valid), 32'h1);
      check_hex("out_data_o", out_data, exp_q[0]);
      @(posedge clk);
      out_ready <= 1'b1;
      wait_drain(500);

      // concurrent traffic with a random sink
      @(negedge clk);
      rand_ready = 1'b1;
      for (int i = 0; i < 200; i++)
         write_word($urandom(), 500, waits);
      @(negedge clk);
      rand_ready = 1'b0;
      @(posedge clk);
      out_ready <= 1'b1;
      wait_drain(1000);
      repeat (5) @(posedge clk);
      read_status(0);
      if (accepted != n + 200)
      begin
         $display("accepted %0d words in total, expected %0d", accepted, n + 200);
         other_errs++;
      end

      $display("errors: %0d mismatches, %0d other failures", mismatch_errs, other_errs);
      if (mismatch_errs + other_errs == 0)
         $display("=== PASS ===");
      else
         $display("=== FAIL ===");
      $finish;
   end

endmodule

// ==== project.f ====
hw/ringbuf_pkg.sv
hw/mem_1rw_sync.sv
hw/apb_ingress.sv
hw/ring_store.sv
hw/stream_egress.sv
hw/ringbuf_top.sv
verification/tb_clock_gen.sv
verification/tb_ringbuf.sv

// ==== Makefile ====
# Verilator build and run for the APB ring buffer

VERILATOR ?= verilator
TOP       ?= tb_ringbuf
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing -Wno-fatal

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove the build directory and the log"
	@echo "variables: VERILATOR TOP FILELIST BUILD_DIR LOG VFLAGS"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "^=== PASS ===$$" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)
